/* run_sim.sh */
#!/bin/sh
# build and run the soc_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing \
  -f soc_lite_top.f \
  --top-module tb_soc_lite \
  -Mdir obj_dir \
  -o tb_soc_lite
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_lite > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its pass line only when every check held
if grep -q "^TB PASSED$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1

/* soc_lite_top.f */
src/soc_lite_pkg.sv
src/axil_addr_demux.sv
src/axil_mem_port.sv
src/boot_rom.sv
src/sram_bank.sv
src/axil_err_slave.sv
src/soc_lite_top.sv
verif/tb_soc_lite.sv

/* src/axil_addr_demux.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_addr_demux (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  soc_lite_pkg::axil_req_t       mgr_req_i,
  output soc_lite_pkg::axil_rsp_t       mgr_rsp_o,
  output soc_lite_pkg::axil_req_t [2:0] slv_req_o,
  input  soc_lite_pkg::axil_rsp_t [2:0] slv_rsp_i
);

  import soc_lite_pkg::*;

  localparam int NumSlv = 3;

  slv_idx_e aw_sel;
  slv_idx_e ar_sel;

  // no new transactions until the cycle after reset
  logic     accept_q;

  // open transaction per direction
  logic     wr_open_q;
  slv_idx_e wr_tgt_q;
  logic     rd_open_q;
  slv_idx_e rd_tgt_q;

  logic aw_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  // anything outside rom and sram goes to the error port
  function automatic slv_idx_e decode(addr_t addr);
    slv_idx_e sel;
    sel = SLV_ERR;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      sel = SLV_ROM;
    end else if (addr >= SramBase && addr < SramBase + SramLength) begin
      sel = SLV_SRAM;
    end
    return sel;
  endfunction

  assign aw_sel = decode(mgr_req_i.aw.addr);
  assign ar_sel = decode(mgr_req_i.ar.addr);

  // ------------------------------------------------------------------
  // routing
  // ------------------------------------------------------------------
  always_comb begin
    mgr_rsp_o = '0;
    for (int i = 0; i < NumSlv; i++) begin
      slv_req_o[i] = '0;
      // payloads are broadcast, only the valids are steered
      slv_req_o[i].aw.addr  = mgr_req_i.aw.addr;
      slv_req_o[i].aw.valid = mgr_req_i.aw.valid & accept_q & ~wr_open_q &
                              (aw_sel == slv_idx_e'(i));
      slv_req_o[i].w.data   = mgr_req_i.w.data;
      slv_req_o[i].w.strb   = mgr_req_i.w.strb;
      slv_req_o[i].w.valid  = mgr_req_i.w.valid & wr_open_q &
                              (wr_tgt_q == slv_idx_e'(i));
      slv_req_o[i].bready   = mgr_req_i.bready & wr_open_q &
                              (wr_tgt_q == slv_idx_e'(i));
      slv_req_o[i].ar.addr  = mgr_req_i.ar.addr;
      slv_req_o[i].ar.valid = mgr_req_i.ar.valid & accept_q & ~rd_open_q &
                              (ar_sel == slv_idx_e'(i));
      slv_req_o[i].rready   = mgr_req_i.rready & rd_open_q &
                              (rd_tgt_q == slv_idx_e'(i));
    end

    // one outstanding write and one outstanding read
    mgr_rsp_o.awready = accept_q & ~wr_open_q & slv_rsp_i[aw_sel].awready;
    mgr_rsp_o.arready = accept_q & ~rd_open_q & slv_rsp_i[ar_sel].arready;

    if (wr_open_q) begin
      mgr_rsp_o.wready = slv_rsp_i[wr_tgt_q].wready;
      mgr_rsp_o.b      = slv_rsp_i[wr_tgt_q].b;
    end
    if (rd_open_q) begin
      mgr_rsp_o.r = slv_rsp_i[rd_tgt_q].r;
    end
  end

  assign aw_hs = mgr_req_i.aw.valid & mgr_rsp_o.awready;
  assign b_hs  = mgr_rsp_o.b.valid & mgr_req_i.bready;
  assign ar_hs = mgr_req_i.ar.valid & mgr_rsp_o.arready;
  assign r_hs  = mgr_rsp_o.r.valid & mgr_req_i.rready;

  // ------------------------------------------------------------------
  // target tracking
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_q  <= 1'b0;
      wr_open_q <= 1'b0;
      wr_tgt_q  <= SLV_ERR;
      rd_open_q <= 1'b0;
      rd_tgt_q  <= SLV_ERR;
    end else begin
      accept_q <= 1'b1;

      if (aw_hs) begin
        wr_open_q <= 1'b1;
        wr_tgt_q  <= aw_sel;
      end else if (b_hs) begin
        wr_open_q <= 1'b0;
      end

      if (ar_hs) begin
        rd_open_q <= 1'b1;
        rd_tgt_q  <= ar_sel;
      end else if (r_hs) begin
        rd_open_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/axil_err_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_err_slave (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  soc_lite_pkg::axil_req_t axil_req_i,
  output soc_lite_pkg::axil_rsp_t axil_rsp_o
);

  import soc_lite_pkg::*;

  logic aw_have_q;
  logic w_have_q;
  logic b_valid_q;
  logic r_valid_q;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic wr_done;

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = ~aw_have_q & ~b_valid_q;
    axil_rsp_o.wready  = ~w_have_q & ~b_valid_q;
    axil_rsp_o.arready = ~r_valid_q;
    axil_rsp_o.b.valid = b_valid_q;
    axil_rsp_o.b.resp  = DECERR;
    axil_rsp_o.r.valid = r_valid_q;
    axil_rsp_o.r.resp  = DECERR;
    axil_rsp_o.r.data  = ErrData;
  end

  assign aw_hs   = axil_req_i.aw.valid & axil_rsp_o.awready;
  assign w_hs    = axil_req_i.w.valid & axil_rsp_o.wready;
  assign ar_hs   = axil_req_i.ar.valid & axil_rsp_o.arready;
  // AW and W may come in either order
  assign wr_done = (aw_have_q | aw_hs) & (w_have_q | w_hs);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      aw_have_q <= (aw_have_q | aw_hs) & ~wr_done;
      w_have_q  <= (w_have_q | w_hs) & ~wr_done;

      if (wr_done) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        b_valid_q <= 1'b0;
      end

      if (ar_hs) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/axil_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_mem_port #(
  parameter bit WritableMem = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  soc_lite_pkg::axil_req_t axil_req_i,
  output soc_lite_pkg::axil_rsp_t axil_rsp_o,
  output soc_lite_pkg::mem_req_t  mem_req_o,
  input  soc_lite_pkg::mem_rsp_t  mem_rsp_i
);

  import soc_lite_pkg::*;

  // word index 0 sits at the start of the region
  localparam addr_t RegionBase = WritableMem ? SramBase : RomBase;
  // read-only regions refuse writes
  localparam resp_e WrResp     = resp_e'(WritableMem ? OKAY : SLVERR);

  // holding registers for the write channels
  addr_t aw_addr_q;
  logic  aw_have_q;
  data_t w_data_q;
  strb_t w_strb_q;
  logic  w_have_q;
  logic  b_valid_q;

  addr_t ar_addr_q;
  logic  rd_req_q;
  logic  r_valid_q;

  logic  aw_hs;
  logic  w_hs;
  logic  ar_hs;
  logic  wr_go;
  addr_t wr_addr;
  data_t wr_data;
  strb_t wr_strb;

  function automatic logic [MemIdxWidth-1:0] word_idx(addr_t addr);
    addr_t offset;
    offset = addr - RegionBase;
    return offset[MemIdxWidth+1:2];
  endfunction

  // ------------------------------------------------------------------
  // bus side
  // ------------------------------------------------------------------
  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = ~aw_have_q & ~b_valid_q;
    axil_rsp_o.wready  = ~w_have_q & ~b_valid_q;
    axil_rsp_o.arready = ~rd_req_q & ~r_valid_q;
    axil_rsp_o.b.valid = b_valid_q;
    axil_rsp_o.b.resp  = WrResp;
    axil_rsp_o.r.valid = r_valid_q;
    axil_rsp_o.r.resp  = OKAY;
    // memory holds its read word until the next read
    axil_rsp_o.r.data  = mem_rsp_i.rdata;
  end

  assign aw_hs = axil_req_i.aw.valid & axil_rsp_o.awready;
  assign w_hs  = axil_req_i.w.valid & axil_rsp_o.wready;
  assign ar_hs = axil_req_i.ar.valid & axil_rsp_o.arready;

  // write goes out once both halves are in, unless a read owns the cycle
  assign wr_go   = (aw_have_q | aw_hs) & (w_have_q | w_hs) & ~rd_req_q;

  assign wr_addr = aw_have_q ? aw_addr_q : axil_req_i.aw.addr;
  assign wr_data = w_have_q ? w_data_q : axil_req_i.w.data;
  assign wr_strb = w_have_q ? w_strb_q : axil_req_i.w.strb;

  // ------------------------------------------------------------------
  // memory side
  // ------------------------------------------------------------------
  always_comb begin
    mem_req_o.req   = rd_req_q | (wr_go & WritableMem);
    mem_req_o.we    = ~rd_req_q;
    mem_req_o.idx   = rd_req_q ? word_idx(ar_addr_q) : word_idx(wr_addr);
    mem_req_o.be    = wr_strb;
    mem_req_o.wdata = wr_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      b_valid_q <= 1'b0;
      rd_req_q  <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      aw_have_q <= (aw_have_q | aw_hs) & ~wr_go;
      w_have_q  <= (w_have_q | w_hs) & ~wr_go;

      if (wr_go) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        b_valid_q <= 1'b0;
      end

      // read request one cycle after AR, data valid the cycle after
      rd_req_q <= ar_hs;
      if (rd_req_q) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= axil_req_i.aw.addr;
    end
    if (w_hs) begin
      w_data_q <= axil_req_i.w.data;
      w_strb_q <= axil_req_i.w.strb;
    end
    if (ar_hs) begin
      ar_addr_q <= axil_req_i.ar.addr;
    end
  end

endmodule

`default_nettype wire

/* src/boot_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module boot_rom (
  input  logic                   clk_i,
  input  soc_lite_pkg::mem_req_t mem_req_i,
  output soc_lite_pkg::mem_rsp_t mem_rsp_o
);

  import soc_lite_pkg::*;

  localparam int RomWords = 16;

  data_t rom_table [RomWords];
  data_t rdata_q;

  // fixed contents, word k carries its own index
  always_comb begin
    for (int k = 0; k < RomWords; k++) begin
      rom_table[k] = RomWordTag + data_t'(k);
    end
  end

  // writes never change the table or the read word
  always_ff @(posedge clk_i) begin
    if (mem_req_i.req && !mem_req_i.we) begin
      rdata_q <= rom_table[mem_req_i.idx[3:0]];
    end
  end

  assign mem_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

/* src/soc_lite_pkg.sv */
`default_nettype none

package soc_lite_pkg;

  // ------------------------------------------------------------------
  // scalar types
  // ------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // subordinate ports behind the address demux
  typedef enum logic [1:0] {
    SLV_ROM  = 2'd0,
    SLV_SRAM = 2'd1,
    SLV_ERR  = 2'd2
  } slv_idx_e;

  // ------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------
  localparam addr_t RomBase    = 32'h0000_1000;
  localparam addr_t RomLength  = 32'h0000_0040;
  localparam addr_t SramBase   = 32'h8000_0000;
  localparam addr_t SramLength = 32'h0000_1000;

  // read pattern of unmapped space
  localparam data_t ErrData    = 32'hBADC_AB1E;
  // rom word k holds this tag plus k
  localparam data_t RomWordTag = 32'hB007_0000;

  localparam int MemIdxWidth = 16;

  // ------------------------------------------------------------------
  // AXI4-Lite channels
  // ------------------------------------------------------------------
  typedef struct packed {
    addr_t addr;
    logic  valid;
  } axil_aw_t;

  typedef struct packed {
    addr_t addr;
    logic  valid;
  } axil_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  valid;
  } axil_w_t;

  typedef struct packed {
    resp_e resp;
    logic  valid;
  } axil_b_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
    logic  valid;
  } axil_r_t;

  // manager to subordinate
  typedef struct packed {
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    logic     bready;
    logic     rready;
  } axil_req_t;

  // subordinate to manager
  typedef struct packed {
    logic    awready;
    logic    wready;
    logic    arready;
    axil_b_t b;
    axil_r_t r;
  } axil_rsp_t;

  // ------------------------------------------------------------------
  // single-cycle memory port
  // ------------------------------------------------------------------
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [MemIdxWidth-1:0] idx;
    strb_t                  be;
    data_t                  wdata;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* src/soc_lite_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_lite_top #(
  parameter int SramWords = 1024
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  soc_lite_pkg::axil_req_t axil_req_i,
  output soc_lite_pkg::axil_rsp_t axil_rsp_o
);

  import soc_lite_pkg::*;

  axil_req_t [2:0] slv_req;
  axil_rsp_t [2:0] slv_rsp;

  mem_req_t rom_mem_req;
  mem_rsp_t rom_mem_rsp;
  mem_req_t sram_mem_req;
  mem_rsp_t sram_mem_rsp;

  // ------------------------------------------------------------------
  // address demux
  // ------------------------------------------------------------------
  axil_addr_demux i_addr_demux (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .mgr_req_i ( axil_req_i ),
    .mgr_rsp_o ( axil_rsp_o ),
    .slv_req_o ( slv_req    ),
    .slv_rsp_i ( slv_rsp    )
  );

  // ------------------------------------------------------------------
  // boot rom
  // ------------------------------------------------------------------
  axil_mem_port #(
    .WritableMem ( 1'b0 )
  ) i_rom_port (
    .clk_i      ( clk_i            ),
    .rst_ni     ( rst_ni           ),
    .axil_req_i ( slv_req[SLV_ROM] ),
    .axil_rsp_o ( slv_rsp[SLV_ROM] ),
    .mem_req_o  ( rom_mem_req      ),
    .mem_rsp_i  ( rom_mem_rsp      )
  );

  boot_rom i_boot_rom (
    .clk_i     ( clk_i       ),
    .mem_req_i ( rom_mem_req ),
    .mem_rsp_o ( rom_mem_rsp )
  );

  // ------------------------------------------------------------------
  // sram
  // ------------------------------------------------------------------
  axil_mem_port #(
    .WritableMem ( 1'b1 )
  ) i_sram_port (
    .clk_i      ( clk_i             ),
    .rst_ni     ( rst_ni            ),
    .axil_req_i ( slv_req[SLV_SRAM] ),
    .axil_rsp_o ( slv_rsp[SLV_SRAM] ),
    .mem_req_o  ( sram_mem_req      ),
    .mem_rsp_i  ( sram_mem_rsp      )
  );

  sram_bank #(
    .SramWords ( SramWords )
  ) i_sram_bank (
    .clk_i     ( clk_i        ),
    .mem_req_i ( sram_mem_req ),
    .mem_rsp_o ( sram_mem_rsp )
  );

  // unmapped space
  axil_err_slave i_err_slave (
    .clk_i      ( clk_i            ),
    .rst_ni     ( rst_ni           ),
    .axil_req_i ( slv_req[SLV_ERR] ),
    .axil_rsp_o ( slv_rsp[SLV_ERR] )
  );

endmodule

`default_nettype wire

/* src/sram_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_bank #(
  parameter int SramWords = 1024
) (
  input  logic                   clk_i,
  input  soc_lite_pkg::mem_req_t mem_req_i,
  output soc_lite_pkg::mem_rsp_t mem_rsp_o
);

  import soc_lite_pkg::*;

  localparam int IdxWidth = $clog2(SramWords);

  data_t               mem_q [SramWords];
  data_t               rdata_q;
  logic [IdxWidth-1:0] word_idx;

  assign word_idx = mem_req_i.idx[IdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        // byte lanes without enable keep their old value
        for (int b = 0; b < 4; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign mem_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

/* verif/tb_soc_lite.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_soc_lite;

  import soc_lite_pkg::*;

  localparam int Timeout = 50;

  typedef struct {
    string name;
    bit    is_write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    resp_e exp_resp;
    data_t exp_rdata;
  } stim_t;

  logic      clk_i;
  logic      rst_ni;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  stim_t  table_q[$];
  data_t  sram_model [addr_t];
  integer seed = 32'h6d70_b928;
  int     err_count = 0;
  int     stall_count = 0;
  int     run_count = 0;
  bit     stalled = 1'b0;

  soc_lite_top #(
    .SramWords ( 1024 )
  ) uut (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .axil_req_i ( axil_req ),
    .axil_rsp_o ( axil_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------
  task automatic check_resp(input string name, input resp_e exp_val, input resp_e act_val);
    if (act_val !== exp_val) begin
      err_count++;
      $display("CHECK FAILED %s: expected %s (%0d) actual %s (%0d)",
               name, exp_val.name(), exp_val, act_val.name(), act_val);
    end
  endtask

  task automatic check_data(input string name, input data_t exp_val, input data_t act_val);
    if (act_val !== exp_val) begin
      err_count++;
      $display("CHECK FAILED %s: expected %08h actual %08h", name, exp_val, act_val);
    end
  endtask

  task automatic check_idle(input string phase);
    if (axil_rsp.b.valid !== 1'b0) begin
      err_count++;
      $display("%s: bvalid is not low", phase);
    end
    if (axil_rsp.r.valid !== 1'b0) begin
      err_count++;
      $display("%s: rvalid is not low", phase);
    end
    if (axil_rsp.awready !== 1'b0) begin
      err_count++;
      $display("%s: awready is not low", phase);
    end
    if (axil_rsp.wready !== 1'b0) begin
      err_count++;
      $display("%s: wready is not low", phase);
    end
    if (axil_rsp.arready !== 1'b0) begin
      err_count++;
      $display("%s: arready is not low", phase);
    end
  endtask

  task automatic report_stall(input string name, input string chan);
    $display("%s: timeout, the %s channel stalled", name, chan);
    stall_count++;
    stalled = 1'b1;
  endtask

  // 0 to 4 cycles of bready or rready low
  function automatic int stall_cycles();
    return $unsigned($random(seed)) % 5;
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------
  task automatic add_write(input string name, input addr_t addr, input data_t data,
                           input strb_t strb, input resp_e resp);
    stim_t e;
    data_t old_word;
    e.name      = name;
    e.is_write  = 1'b1;
    e.addr      = addr;
    e.wdata     = data;
    e.strb      = strb;
    e.exp_resp  = resp;
    e.exp_rdata = '0;
    table_q.push_back(e);
    // only sram writes complete with OKAY
    if (resp == OKAY) begin
      old_word = sram_model.exists(addr) ? sram_model[addr] : '0;
      sram_model[addr] = merge_bytes(old_word, data, strb);
    end
  endtask

  task automatic add_read(input string name, input addr_t addr, input resp_e resp,
                          input data_t rdata);
    stim_t e;
    e.name      = name;
    e.is_write  = 1'b0;
    e.addr      = addr;
    e.wdata     = '0;
    e.strb      = '0;
    e.exp_resp  = resp;
    e.exp_rdata = rdata;
    table_q.push_back(e);
  endtask

  task automatic add_sram_read(input string name, input addr_t addr);
    add_read(name, addr, OKAY, sram_model[addr]);
  endtask

  task automatic build_table();
    add_read("rom_rd_0", RomBase, OKAY, RomWordTag + 32'd0);
    add_read("rom_rd_5", RomBase + 32'h14, OKAY, RomWordTag + 32'd5);
    add_read("rom_rd_15", RomBase + 32'h3C, OKAY, RomWordTag + 32'd15);
    add_write("sram_wr_0", SramBase, 32'h1234_5678, 4'hF, OKAY);
    add_write("sram_wr_last", SramBase + 32'hFFC, 32'hCAFE_F00D, 4'hF, OKAY);
    add_sram_read("sram_rd_0", SramBase);
    add_sram_read("sram_rd_last", SramBase + 32'hFFC);
    add_write("sram_wr_part", SramBase, 32'hAABB_CCDD, 4'b0101, OKAY);
    add_sram_read("sram_rd_part", SramBase);
    add_write("rom_wr", RomBase + 32'h8, 32'hDEAD_BEEF, 4'hF, SLVERR);
    add_read("rom_rd_after_wr", RomBase + 32'h8, OKAY, RomWordTag + 32'd2);
    add_read("rd_past_rom", RomBase + RomLength, DECERR, ErrData);
    add_read("rd_past_sram", SramBase + SramLength, DECERR, ErrData);
    add_read("rd_below_rom", RomBase - 32'd4, DECERR, ErrData);
    add_read("rd_zero", 32'h0000_0000, DECERR, ErrData);
    add_write("wr_past_rom", RomBase + RomLength, 32'h0101_0101, 4'hF, DECERR);
    add_write("wr_past_sram", SramBase + SramLength, 32'h0202_0202, 4'hF, DECERR);
    add_write("wr_top", 32'hFFFF_FFFC, 32'h0303_0303, 4'h3, DECERR);
  endtask

  // ------------------------------------------------------------------
  // bus driver tasks
  // ------------------------------------------------------------------
  task automatic drive_write(input string name, input addr_t addr, input data_t data,
                             input strb_t strb, output resp_e resp);
    int    waits;
    int    delay;
    bit    aw_done;
    bit    w_done;
    bit    aw_fire;
    bit    w_fire;
    resp_e hold_resp;
    resp = OKAY;
    @(posedge clk_i);
    axil_req.aw.addr  <= addr;
    axil_req.aw.valid <= 1'b1;
    axil_req.w.data   <= data;
    axil_req.w.strb   <= strb;
    axil_req.w.valid  <= 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    waits   = 0;
    // AW and W finish on their own edges
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_fire = !aw_done && axil_rsp.awready;
      w_fire  = !w_done && axil_rsp.wready;
      @(posedge clk_i);
      if (aw_fire) begin
        axil_req.aw.valid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_fire) begin
        axil_req.w.valid <= 1'b0;
        w_done = 1'b1;
      end
      waits++;
      if (!(aw_done && w_done) && waits >= Timeout) begin
        report_stall(name, aw_done ? "write data" : "write address");
        return;
      end
    end

    waits = 0;
    @(negedge clk_i);
    while (!axil_rsp.b.valid) begin
      waits++;
      if (waits >= Timeout) begin
        report_stall(name, "write response");
        return;
      end
      @(negedge clk_i);
    end
    hold_resp = axil_rsp.b.resp;
    delay = stall_cycles();
    for (int i = 0; i < delay; i++) begin
      @(negedge clk_i);
      if (!axil_rsp.b.valid) begin
        err_count++;
        $display("%s: bvalid dropped while bready was low", name);
      end
      check_resp({name, " b hold"}, hold_resp, axil_rsp.b.resp);
    end
    @(posedge clk_i);
    axil_req.bready <= 1'b1;
    @(negedge clk_i);
    resp = axil_rsp.b.resp;
    @(posedge clk_i);
    axil_req.bready <= 1'b0;
  endtask

  task automatic drive_read(input string name, input addr_t addr, output resp_e resp,
                            output data_t data);
    int    waits;
    int    delay;
    bit    ar_fire;
    resp_e hold_resp;
    data_t hold_data;
    resp = OKAY;
    data = '0;
    @(posedge clk_i);
    axil_req.ar.addr  <= addr;
    axil_req.ar.valid <= 1'b1;
    ar_fire = 1'b0;
    waits   = 0;
    while (!ar_fire) begin
      @(negedge clk_i);
      ar_fire = axil_rsp.arready;
      @(posedge clk_i);
      waits++;
      if (!ar_fire && waits >= Timeout) begin
        report_stall(name, "read address");
        return;
      end
    end
    axil_req.ar.valid <= 1'b0;

    waits = 0;
    @(negedge clk_i);
    while (!axil_rsp.r.valid) begin
      waits++;
      if (waits >= Timeout) begin
        report_stall(name, "read data");
        return;
      end
      @(negedge clk_i);
    end
    hold_resp = axil_rsp.r.resp;
    hold_data = axil_rsp.r.data;
    delay = stall_cycles();
    for (int i = 0; i < delay; i++) begin
      @(negedge clk_i);
      if (!axil_rsp.r.valid) begin
        err_count++;
        $display("%s: rvalid dropped while rready was low", name);
      end
      check_resp({name, " r hold"}, hold_resp, axil_rsp.r.resp);
      check_data({name, " r hold"}, hold_data, axil_rsp.r.data);
    end
    @(posedge clk_i);
    axil_req.rready <= 1'b1;
    @(negedge clk_i);
    resp = axil_rsp.r.resp;
    data = axil_rsp.r.data;
    @(posedge clk_i);
    axil_req.rready <= 1'b0;
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    resp_e got_resp;
    data_t got_data;
    axil_req <= '0;
    rst_ni   <= 1'b0;
    build_table();

    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_idle("during reset");
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle("after reset");

    for (int i = 0; i < table_q.size(); i++) begin
      if (!stalled) begin
        if (table_q[i].is_write) begin
          drive_write(table_q[i].name, table_q[i].addr, table_q[i].wdata,
                      table_q[i].strb, got_resp);
        end else begin
          drive_read(table_q[i].name, table_q[i].addr, got_resp, got_data);
        end
        if (!stalled) begin
          check_resp(table_q[i].name, table_q[i].exp_resp, got_resp);
          if (!table_q[i].is_write) begin
            check_data(table_q[i].name, table_q[i].exp_rdata, got_data);
          end
          run_count++;
        end
      end
    end

    repeat (2) @(posedge clk_i);
    $display("summary: %0d of %0d entries run, %0d check errors, %0d timeouts",
             run_count, table_q.size(), err_count, stall_count);
    if (err_count == 0 && stall_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
